// File: verilog.f
design/alu_pkg.sv
design/alu_cond_eval.sv
design/alu_adder.sv
design/alu_result_mux.sv
design/alu_flag_gen.sv
design/alu_core.sv
verif/alu_clk_gen.sv
verif/alu_props.sv
verif/alu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module alu_tb -f verilog.f -o alu_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/alu_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0

// File: verif/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
  import alu_pkg::*;

  localparam int period_ns = 10;
  localparam int reset_cycles = 8;
  localparam int n_random = 3000;
  localparam int n_directed = 2 * 16 + 2;
  localparam int limit_ns = (reset_cycles + n_directed + n_random + 4) * period_ns + 500;

  typedef struct packed {
    alu_req_t req;
    alu_rsp_t rsp;
  } expect_t;

  logic     clk;
  logic     rst;
  logic     in_valid;
  alu_req_t req;
  logic     out_valid;
  alu_rsp_t rsp;

  expect_t  pending[$];
  alu_rsp_t last_rsp;

  alu_clk_gen #(.period_ns(period_ns)) u_clk (.clk(clk));

  alu_core u_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  bind alu_core alu_props u_props (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  // pairs of codes, odd member inverted, except p/always
  // c is the borrow, so unsigned above means no borrow
  function automatic logic cond_holds(input alu_flags_t f, input cond_e cc);
    logic lt;
    logic hit;
    lt = f.s != f.o;
    case (cc[3:1])
      3'd0: hit = f.z;
      3'd1: hit = f.s;
      3'd2: hit = !f.c && !f.z;
      3'd3: hit = !f.c;
      3'd4: hit = !lt && !f.z;
      3'd5: hit = !lt;
      3'd6: hit = f.o;
      default: hit = f.p;
    endcase
    if (cc == cc_always) begin
      return 1'b1;
    end
    return hit ^ cc[0];
  endfunction

  // add or subtract at width w, c and a are borrows on subtract
  function automatic alu_rsp_t arith(input logic [63:0] a, input logic [63:0] b,
                                     input logic sub, input int w);
    alu_rsp_t    m;
    logic [63:0] mask;
    logic [63:0] top;
    logic [64:0] wide;
    logic [64:0] cbit;
    logic        sa;
    logic        sb;
    logic        sr;
    mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    top = 64'd1 << (w - 1);
    if (sub) begin
      wide = {1'b0, a & mask} - {1'b0, b & mask};
    end else begin
      wide = {1'b0, a & mask} + {1'b0, b & mask};
    end
    m = '0;
    m.sets_flags = 1'b1;
    m.result = wide[63:0] & mask;
    cbit = wide >> w;
    sa = (a & top) != '0;
    sb = (b & top) != '0;
    sr = (m.result & top) != '0;
    if (sub) begin
      m.flags.c = (a & mask) < (b & mask);
      m.flags.a = a[3:0] < b[3:0];
      m.flags.o = (sa != sb) && (sr != sa);
    end else begin
      m.flags.c = cbit[0];
      m.flags.a = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
      m.flags.o = (sa == sb) && (sr != sa);
    end
    m.flags.s = sr;
    m.flags.z = m.result == '0;
    return m;
  endfunction

  function automatic alu_rsp_t logic_op(input logic [63:0] value, input int w);
    alu_rsp_t    m;
    logic [63:0] mask;
    logic [63:0] top;
    mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    top = 64'd1 << (w - 1);
    m = '0;
    m.sets_flags = 1'b1;
    m.result = value & mask;
    m.flags.s = (value & top) != '0;
    m.flags.z = (value & mask) == '0;
    return m;
  endfunction

  function automatic alu_rsp_t model(input alu_req_t r);
    alu_rsp_t m;
    m = '0;
    case (r.op)
      op_add64: m = arith(r.a, r.b, 1'b0, 64);
      op_add32: m = arith(r.a, r.b, 1'b0, 32);
      op_sub64: m = arith(r.a, r.b, 1'b1, 64);
      op_sub32: m = arith(r.a, r.b, 1'b1, 32);
      op_cmp16: begin
        m = arith(r.a, r.b, 1'b1, 16);
        m.result = '0;
      end
      op_cmp8: begin
        m = arith(r.a, r.b, 1'b1, 8);
        m.result = '0;
      end
      op_and64:  m = logic_op(r.a & r.b, 64);
      op_and32:  m = logic_op(r.a & r.b, 32);
      op_or64:   m = logic_op(r.a | r.b, 64);
      op_or32:   m = logic_op(r.a | r.b, 32);
      op_xor64:  m = logic_op(r.a ^ r.b, 64);
      op_xor32:  m = logic_op(r.a ^ r.b, 32);
      op_xnor64: m = logic_op(~(r.a ^ r.b), 64);
      op_mov64:  m.result = r.b;
      op_mov32:  m.result = 64'(r.b[31:0]);
      op_zxt8:   m.result = 64'(r.b[7:0]);
      op_zxt16:  m.result = 64'(r.b[15:0]);
      op_sxt8:   m.result = 64'(signed'(r.b[7:0]));
      op_sxt16:  m.result = 64'(signed'(r.b[15:0]));
      op_sxt32:  m.result = 64'(signed'(r.b[31:0]));
      op_cmov:   m.result = cond_holds(r.flags_in, r.cond) ? r.b : r.a;
      op_cset:   m.result = 64'(cond_holds(r.flags_in, r.cond));
      op_lahf: begin
        m.flags = r.a[5:0];
        m.sets_flags = 1'b1;
      end
      op_sahf:   m.result = 64'(r.flags_in);
      default:   m = '0;
    endcase
    return m;
  endfunction

  // edge values at every flag width, else fully random
  function automatic logic [63:0] pick_operand();
    case ($urandom_range(0, 9))
      0: return '0;
      1: return '1;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'h7fff_ffff_ffff_ffff;
      4: return {$urandom(), 32'h8000_0000};
      5: return {$urandom(), 32'h7fff_ffff};
      6: return {$urandom(), 16'($urandom()), 16'h8000};
      7: return {$urandom(), 24'($urandom()), 8'h80};
      default: return {$urandom(), $urandom()};
    endcase
  endfunction

  function automatic alu_req_t random_req();
    alu_req_t   r;
    logic [4:0] opv;
    logic [3:0] ccv;
    opv = 5'($urandom_range(0, 23));
    ccv = 4'($urandom());
    r.op = alu_op_e'(opv);
    r.cond = cond_e'(ccv);
    r.a = pick_operand();
    r.b = pick_operand();
    r.flags_in = 6'($urandom());
    return r;
  endfunction

  task automatic check_response();
    expect_t e;
    if (out_valid) begin
      if (pending.size() != 1) begin
        abort_run("response arrived without a request one cycle earlier");
      end else begin
        e = pending.pop_front();
        check_value({e.req.op.name(), " result"}, e.rsp.result, rsp.result);
        check_value({e.req.op.name(), " flags"}, 64'(e.rsp.flags), 64'(rsp.flags));
        check_value({e.req.op.name(), " sets_flags"}, 64'(e.rsp.sets_flags),
                    64'(rsp.sets_flags));
        last_rsp = rsp;
      end
    end else if (pending.size() != 0) begin
      abort_run("no response one cycle after a valid request");
    end else begin
      check_value("idle hold result", last_rsp.result, rsp.result);
      check_value("idle hold flags", 64'(last_rsp.flags), 64'(rsp.flags));
      check_value("idle hold sets_flags", 64'(last_rsp.sets_flags),
                  64'(rsp.sets_flags));
    end
  endtask

  task automatic step(input logic valid, input alu_req_t r);
    expect_t e;
    @(posedge clk);
    #1;
    check_response();
    in_valid = valid;
    req = r;
    if (valid) begin
      e.req = r;
      e.rsp = model(r);
      pending.push_back(e);
    end
  endtask

  initial begin
    #(limit_ns);
    abort_run("watchdog timeout, the run did not finish");
  end

  initial begin
    alu_req_t r;
    void'($urandom(15176));
    rst = 1'b1;
    in_valid = 1'b0;
    req = '0;
    last_rsp = '0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int cc = 0; cc < 16; cc++) begin
      r = random_req();
      r.cond = cond_e'(4'(cc));
      r.op = op_cmov;
      step(1'b1, r);
      r.op = op_cset;
      step(1'b1, r);
    end
    r = random_req();
    r.op = op_lahf;
    step(1'b1, r);
    r.op = op_sahf;
    step(1'b1, r);

    for (int i = 0; i < n_random; i++) begin
      r = random_req();
      step($urandom_range(0, 4) != 0, r); // about one idle in five
    end
    step(1'b0, random_req());
    step(1'b0, random_req());

    if (pending.size() != 0) begin
      $display("ERROR: %0d responses never arrived", pending.size());
      $display("=== FAIL ===");
      $fatal(1, "missing responses");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verif/alu_props.sv
`timescale 1ns/1ps
`default_nettype none

module alu_props (
  input logic              clk,
  input logic              rst,
  input logic              in_valid,
  input logic              out_valid,
  input alu_pkg::alu_rsp_t rsp
);

  a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high after a reset cycle");

  // one cycle latency, no stall
  a_valid_follows: assert property (@(posedge clk) !rst |=> (out_valid == $past(in_valid)))
    else $error("out_valid does not follow in_valid by one cycle");

  a_flags_quiet: assert property (@(posedge clk) (!rst && !rsp.sets_flags) |-> rsp.flags == '0)
    else $error("flags nonzero while sets_flags is low");

endmodule

`default_nettype wire

// File: verif/alu_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module alu_clk_gen #(
  parameter int period_ns = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: design/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  alu_pkg::alu_req_t req,
  output logic              out_valid,
  output alu_pkg::alu_rsp_t rsp
);
  import alu_pkg::*;

  logic [data_w-1:0] sum;
  logic [data_w-1:0] result;
  alu_carry_t        carry;
  logic              sub;
  logic              cond_true;

  // compares run through the adder as subtracts
  assign sub = req.op inside {op_sub64, op_sub32, op_cmp16, op_cmp8};

  alu_adder u_adder (
    .a     (req.a),
    .b     (req.b),
    .sub   (sub),
    .sum   (sum),
    .carry (carry)
  );

  alu_cond_eval u_cond (
    .flags     (req.flags_in),
    .cond      (req.cond),
    .cond_true (cond_true)
  );

  alu_result_mux u_mux (
    .req       (req),
    .sum       (sum),
    .cond_true (cond_true),
    .result    (result)
  );

  alu_flag_gen u_flags (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .result    (result),
    .carry     (carry),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

// File: design/alu_flag_gen.sv
`timescale 1ns/1ps
`default_nettype none

module alu_flag_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  alu_pkg::alu_req_t          req,
  input  logic [alu_pkg::data_w-1:0] result,
  input  alu_pkg::alu_carry_t        carry,
  output logic                       out_valid,
  output alu_pkg::alu_rsp_t          rsp
);
  import alu_pkg::*;

  logic [15:0] cmp_diff; // compares only go to 16 bits
  logic        is_sub;
  alu_flags_t  flags_next;
  logic        sets_next;

  // signed overflow, b is inverted for subtract
  function automatic logic ovf(input logic sa, input logic sb, input logic sr,
                               input logic sub);
    logic sbx;
    sbx = sb ^ sub;
    return (sa == sbx) && (sr != sa);
  endfunction

  assign is_sub = req.op inside {op_sub64, op_sub32, op_cmp16, op_cmp8};
  assign cmp_diff = req.a[15:0] - req.b[15:0];

  always_comb begin
    flags_next = '0;
    sets_next = 1'b0;
    case (req.op)
      op_add64, op_sub64: begin
        sets_next = 1'b1;
        flags_next.c = carry.c64 ^ is_sub; // borrow on subtract
        flags_next.o = ovf(req.a[63], req.b[63], result[63], is_sub);
        flags_next.a = carry.c4 ^ is_sub;
        flags_next.s = result[63];
        flags_next.z = (result == '0);
      end
      op_add32, op_sub32: begin
        sets_next = 1'b1;
        flags_next.c = carry.c32 ^ is_sub;
        flags_next.o = ovf(req.a[31], req.b[31], result[31], is_sub);
        flags_next.a = carry.c4 ^ is_sub;
        flags_next.s = result[31];
        flags_next.z = (result[31:0] == '0);
      end
      op_cmp16: begin
        sets_next = 1'b1;
        flags_next.c = ~carry.c16;
        flags_next.o = ovf(req.a[15], req.b[15], cmp_diff[15], 1'b1);
        flags_next.a = ~carry.c4;
        flags_next.s = cmp_diff[15];
        flags_next.z = (cmp_diff == '0);
      end
      op_cmp8: begin
        sets_next = 1'b1;
        flags_next.c = ~carry.c8;
        flags_next.o = ovf(req.a[7], req.b[7], cmp_diff[7], 1'b1);
        flags_next.a = ~carry.c4;
        flags_next.s = cmp_diff[7];
        flags_next.z = (cmp_diff[7:0] == '0);
      end
      op_and64, op_or64, op_xor64, op_xnor64: begin
        sets_next = 1'b1;
        flags_next.s = result[63];
        flags_next.z = (result == '0);
      end
      op_and32, op_or32, op_xor32: begin
        sets_next = 1'b1;
        flags_next.s = result[31];
        flags_next.z = (result[31:0] == '0);
      end
      op_lahf: begin
        sets_next = 1'b1;
        flags_next = req.a[flags_w-1:0];
      end
      default: begin
        flags_next = '0;
        sets_next = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      rsp <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin // idle cycles keep the last response
        rsp.result <= result;
        rsp.flags <= flags_next;
        rsp.sets_flags <= sets_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/alu_result_mux.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result_mux (
  input  alu_pkg::alu_req_t          req,
  input  logic [alu_pkg::data_w-1:0] sum,
  input  logic                       cond_true,
  output logic [alu_pkg::data_w-1:0] result
);
  import alu_pkg::*;

  logic [data_w-1:0] val_and;
  logic [data_w-1:0] val_or;
  logic [data_w-1:0] val_xor;

  assign val_and = req.a & req.b;
  assign val_or  = req.a | req.b;
  assign val_xor = req.a ^ req.b;

  always_comb begin
    result = '0;
    case (req.op)
      op_add64, op_sub64: result = sum;
      op_add32, op_sub32: result = {32'b0, sum[31:0]};

      op_and64:  result = val_and;
      op_and32:  result = {32'b0, val_and[31:0]};
      op_or64:   result = val_or;
      op_or32:   result = {32'b0, val_or[31:0]};
      op_xor64:  result = val_xor;
      op_xor32:  result = {32'b0, val_xor[31:0]};
      op_xnor64: result = ~val_xor;

      op_mov64: result = req.b;
      op_mov32: result = {32'b0, req.b[31:0]};
      op_zxt8:  result = {{(data_w-8){1'b0}}, req.b[7:0]};
      op_zxt16: result = {{(data_w-16){1'b0}}, req.b[15:0]};
      op_sxt8:  result = {{(data_w-8){req.b[7]}}, req.b[7:0]};
      op_sxt16: result = {{(data_w-16){req.b[15]}}, req.b[15:0]};
      op_sxt32: result = {{(data_w-32){req.b[31]}}, req.b[31:0]};

      // b when the condition holds, else keep a
      op_cmov: result = cond_true ? req.b : req.a;
      op_cset: result = {{(data_w-1){1'b0}}, cond_true};
      op_sahf: result = {{(data_w-flags_w){1'b0}}, req.flags_in};

      // compares and lahf only produce flags
      op_cmp16, op_cmp8, op_lahf: result = '0;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/alu_adder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_adder (
  input  logic [alu_pkg::data_w-1:0] a,
  input  logic [alu_pkg::data_w-1:0] b,
  input  logic                       sub,
  output logic [alu_pkg::data_w-1:0] sum,
  output alu_pkg::alu_carry_t        carry
);
  import alu_pkg::*;

  logic [data_w-1:0] bx;
  logic c4;
  logic c8;
  logic c16;
  logic c32;
  logic c64;

  // a - b as a + ~b + 1
  assign bx = sub ? ~b : b;

  // split at each flag width so narrow carries come out directly
  assign {c4, sum[3:0]} = {1'b0, a[3:0]} + {1'b0, bx[3:0]} + {4'b0, sub};
  assign {c8, sum[7:4]} = {1'b0, a[7:4]} + {1'b0, bx[7:4]} + {4'b0, c4};
  assign {c16, sum[15:8]} = {1'b0, a[15:8]} + {1'b0, bx[15:8]} + {8'b0, c8};
  assign {c32, sum[31:16]} = {1'b0, a[31:16]} + {1'b0, bx[31:16]} + {16'b0, c16};
  assign {c64, sum[63:32]} = {1'b0, a[63:32]} + {1'b0, bx[63:32]} + {32'b0, c32};

  assign carry.c4  = c4;
  assign carry.c8  = c8;
  assign carry.c16 = c16;
  assign carry.c32 = c32;
  assign carry.c64 = c64;

endmodule

`default_nettype wire

// File: design/alu_cond_eval.sv
`timescale 1ns/1ps
`default_nettype none

module alu_cond_eval (
  input  alu_pkg::alu_flags_t flags,
  input  alu_pkg::cond_e      cond,
  output logic                cond_true
);
  import alu_pkg::*;

  logic lt; // signed less than

  assign lt = flags.s ^ flags.o;

  // c is a borrow after subtract, so unsigned above needs it clear
  always_comb begin
    case (cond)
      cc_z:      cond_true = flags.z;
      cc_nz:     cond_true = ~flags.z;
      cc_s:      cond_true = flags.s;
      cc_ns:     cond_true = ~flags.s;
      cc_ugt:    cond_true = ~flags.c & ~flags.z;
      cc_ule:    cond_true = flags.c | flags.z;
      cc_uge:    cond_true = ~flags.c;
      cc_ult:    cond_true = flags.c;
      cc_sgt:    cond_true = ~(lt | flags.z);
      cc_sle:    cond_true = lt | flags.z;
      cc_sge:    cond_true = ~lt;
      cc_slt:    cond_true = lt;
      cc_o:      cond_true = flags.o;
      cc_no:     cond_true = ~flags.o;
      cc_p:      cond_true = flags.p;
      cc_always: cond_true = 1'b1;
      default:   cond_true = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: design/alu_pkg.sv
`default_nettype none

package alu_pkg;

  localparam int data_w = 64;
  localparam int flags_w = 6;

  typedef enum logic [4:0] {
    op_add64,
    op_add32,
    op_sub64,
    op_sub32,
    op_cmp16,
    op_cmp8,
    op_and64,
    op_and32,
    op_or64,
    op_or32,
    op_xor64,
    op_xor32,
    op_xnor64,
    op_mov64,
    op_mov32,
    op_zxt8,
    op_zxt16,
    op_sxt8,
    op_sxt16,
    op_sxt32,
    op_cmov,
    op_cset,
    op_lahf,
    op_sahf
  } alu_op_e;

  // condition codes, same order as the jump table
  typedef enum logic [3:0] {
    cc_z,
    cc_nz,
    cc_s,
    cc_ns,
    cc_ugt,
    cc_ule,
    cc_uge,
    cc_ult,
    cc_sgt,
    cc_sle,
    cc_sge,
    cc_slt,
    cc_o,
    cc_no,
    cc_p,
    cc_always
  } cond_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } alu_flags_t;

  // carry out of bits 3, 7, 15, 31, 63
  typedef struct packed {
    logic c4;
    logic c8;
    logic c16;
    logic c32;
    logic c64;
  } alu_carry_t;

  typedef struct packed {
    alu_op_e           op;
    cond_e             cond;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    alu_flags_t        flags_in;
  } alu_req_t;

  typedef struct packed {
    logic [data_w-1:0] result;
    alu_flags_t        flags;
    logic              sets_flags;
  } alu_rsp_t;

endpackage

`default_nettype wire
